//--- Makefile
RTL = logic/cache_dir_addr_pkg.sv logic/cache_dir_resp_pkg.sv logic/line_state_regfile.sv \
      logic/cache_dir_replace.sv logic/cache_dir_tag_store.sv logic/cache_dir_sweep_cnt.sv \
      logic/cache_dir_ctrl_fsm.sv logic/cache_dir_top.sv

.PHONY: all run_tree run_mru lint clean

all: run_tree run_mru

run_tree:
	verilator --binary --timing --assert -GREP_POLICY=2 --top-module cache_dir_tb \
		--Mdir obj_tree -f cache_dir.f
	./obj_tree/Vcache_dir_tb > sim_tree.log
	cat sim_tree.log
	! grep -q "Simulation failed" sim_tree.log

run_mru:
	verilator --binary --timing --assert -GREP_POLICY=1 --top-module cache_dir_tb \
		--Mdir obj_mru -f cache_dir.f
	./obj_mru/Vcache_dir_tb > sim_mru.log
	cat sim_mru.log
	! grep -q "Simulation failed" sim_mru.log

lint:
	verilator --lint-only +incdir+logic --top-module cache_dir_top $(RTL)

clean:
	rm -rf obj_tree obj_mru sim_tree.log sim_mru.log

//--- cache_dir.f
+incdir+logic
logic/cache_dir_addr_pkg.sv
logic/cache_dir_resp_pkg.sv
logic/line_state_regfile.sv
logic/cache_dir_replace.sv
logic/cache_dir_tag_store.sv
logic/cache_dir_sweep_cnt.sv
logic/cache_dir_ctrl_fsm.sv
logic/cache_dir_top.sv
verif/cache_dir_properties.sv
verif/cache_dir_tb.sv

//--- logic/cache_dir_addr_pkg.sv
`include "cache_dir_params.svh"

// request side of the directory: address split and the registered lookup
package cache_dir_addr_pkg;

   typedef logic [`CACHE_DIR_TAG_W-1:0]    tag_t;      // upper address bits
   typedef logic [`CACHE_DIR_NLINES_W-1:0] line_idx_t; // set index
   typedef logic [`CACHE_DIR_OFFSET_W-1:0] offset_t;   // byte in line, not looked at

   // field view, msb first
   typedef struct packed {
      tag_t      tag;
      line_idx_t line;
      offset_t   offset;
   } addr_fields_t;

   // same 16 bit word seen raw or split into fields
   typedef union packed {
      logic [`CACHE_DIR_ADDR_W-1:0] raw;    // as driven on the port
      addr_fields_t                 fields; // as used by the lookup
   } cache_addr_t;

   // registered request, only the address for now
   typedef struct packed {
      cache_addr_t addr;
   } lookup_req_t;

endpackage

//--- logic/cache_dir_ctrl_fsm.sv
`timescale 1ns/1ps

`include "cache_dir_params.svh"

// idle / lookup / sweep sequencing and the registered response
module cache_dir_ctrl_fsm import cache_dir_addr_pkg::*, cache_dir_resp_pkg::*; (
   input  logic         clk_i,
   input  logic         arst_n_i,
   input  logic         req_i,
   input  cache_addr_t  addr_i,
   input  logic         flush_i,
   input  logic         sweep_last_i,
   input  way_vec_t     hit_1hot_i,
   input  way_idx_t     hit_idx_i,
   input  way_vec_t     victim_1hot_i,
   input  logic         evict_valid_i,
   input  tag_t         evict_tag_i,
   output lookup_req_t  req_o,
   output logic         lookup_o,
   output logic         sweep_o,
   output logic         busy_o,
   output logic         resp_valid_o,
   output lookup_resp_t resp_o,
   output logic         flush_done_o
);

   typedef enum logic [1:0] {ST_IDLE, ST_LOOKUP, ST_SWEEP} state_t;

   state_t       state_q, state_d;
   lookup_req_t  req_q;
   lookup_resp_t resp_q, resp_d;
   logic         resp_valid_q, flush_done_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE:   if (flush_i) state_d = ST_SWEEP;  // flush wins over a request
                    else if (req_i) state_d = ST_LOOKUP;
         ST_LOOKUP: state_d = ST_IDLE;                // single cycle lookup
         ST_SWEEP:  if (sweep_last_i) state_d = ST_IDLE;
         default:   state_d = ST_IDLE;
      endcase
   end

   // response built from the tag store and the replacement unit
   always_comb begin
      resp_d.hit         = |hit_1hot_i;
      resp_d.way         = resp_d.hit ? hit_idx_i : onehot_to_idx(victim_1hot_i);
      resp_d.evict_valid = evict_valid_i;
      resp_d.evict_tag   = evict_valid_i ? evict_tag_i : '0;
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q      <= ST_IDLE;
         resp_valid_q <= 1'b0;
         flush_done_q <= 1'b0;
      end else begin
         state_q      <= state_d;
         resp_valid_q <= (state_q == ST_LOOKUP);                 // pulse with the commit
         flush_done_q <= (state_q == ST_SWEEP) && sweep_last_i;  // last line cleared
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == ST_IDLE && req_i && !flush_i) begin
         req_q.addr.fields <= addr_i.fields;
      end
      if (state_q == ST_LOOKUP) begin
         resp_q <= resp_d;
      end
   end

   assign req_o        = req_q;
   assign lookup_o     = (state_q == ST_LOOKUP);
   assign sweep_o      = (state_q == ST_SWEEP);
   assign busy_o       = (state_q != ST_IDLE); // strobes are dropped while high
   assign resp_valid_o = resp_valid_q;
   assign resp_o       = resp_q;
   assign flush_done_o = flush_done_q;

endmodule

//--- logic/cache_dir_params.svh
`ifndef CACHE_DIR_PARAMS_SVH
`define CACHE_DIR_PARAMS_SVH

// directory geometry
`define CACHE_DIR_NWAYS     4  // ways per line, power of two for the tree policy
`define CACHE_DIR_NWAYS_W   2  // way index width
`define CACHE_DIR_NLINES_W  3  // 8 lines
`define CACHE_DIR_OFFSET_W  2  // byte offset inside a line

// request word and what is left for the tag
`define CACHE_DIR_ADDR_W    16
`define CACHE_DIR_TAG_W     (`CACHE_DIR_ADDR_W - `CACHE_DIR_NLINES_W - `CACHE_DIR_OFFSET_W)

// replacement policy codes
`define CACHE_DIR_PLRU_MRU  1  // one mru bit per way
`define CACHE_DIR_PLRU_TREE 2  // binary tree of NWAYS-1 node bits

// tree policy unless the top says otherwise
`define CACHE_DIR_DEFAULT_POLICY `CACHE_DIR_PLRU_TREE

`endif

//--- logic/cache_dir_replace.sv
`timescale 1ns/1ps

`include "cache_dir_params.svh"

// victim choice and history update for the indexed line
module cache_dir_replace import cache_dir_resp_pkg::*; #(
   parameter int REP_POLICY = `CACHE_DIR_DEFAULT_POLICY
) (
   input  logic                          clk_i,
   input  logic                          arst_n_i,
   input  logic                          we_i,
   input  logic [`CACHE_DIR_NLINES_W-1:0] line_i,
   input  way_vec_t                      way_hit_1hot_i, // way just used, zero clears
   output way_vec_t                      way_select_o    // victim, always one-hot
);

   localparam int NWAYS   = `CACHE_DIR_NWAYS;
   localparam int NWAYS_W = `CACHE_DIR_NWAYS_W;
   // mru keeps a bit per way, the tree a bit per inner node
   localparam int STATE_W = (REP_POLICY == `CACHE_DIR_PLRU_MRU) ? NWAYS : NWAYS - 1;

   logic [STATE_W-1:0] state_q; // history of the line at line_i
   logic [STATE_W-1:0] state_d;

   if (REP_POLICY == `CACHE_DIR_PLRU_MRU) begin : g_plru_mru
      way_vec_t mru_set;

      assign mru_set = state_q | way_hit_1hot_i;

      // saturating set keeps only the newest way
      assign state_d = !(|way_hit_1hot_i) ? '0 :
                       (&mru_set)         ? way_hit_1hot_i : mru_set;

      // isolate the lowest clear bit
      assign way_select_o = ~state_q & (state_q + 1'b1);
   end else begin : g_plru_tree
      // node n has children 2n and 2n+1, leaves NWAYS..2*NWAYS-1 are the ways
      logic [NWAYS-1:1] tree_q;
      logic [NWAYS-1:1] tree_d;
      logic [NWAYS_W:0] vic_node;
      logic [NWAYS_W:0] upd_node;
      way_idx_t         upd_idx;

      assign tree_q  = state_q;
      assign state_d = tree_d;
      assign upd_idx = onehot_to_idx(way_hit_1hot_i);

      // walk from the root, node bit 1 means go right
      always_comb begin
         vic_node = (NWAYS_W + 1)'(1);
         for (int l = 0; l < NWAYS_W; l++) begin
            vic_node = {vic_node[NWAYS_W-1:0], tree_q[vic_node]};
         end
         way_select_o = '0;
         way_select_o[vic_node[NWAYS_W-1:0]] = 1'b1; // leaf minus NWAYS
      end

      // point every node on the used path away from the used way
      always_comb begin
         tree_d   = '0; // sweep writes an empty tree
         upd_node = (NWAYS_W + 1)'(1);
         if (|way_hit_1hot_i) begin
            tree_d = tree_q; // nodes off the path keep their value
            for (int l = NWAYS_W - 1; l >= 0; l--) begin
               tree_d[upd_node] = ~upd_idx[l];
               upd_node = {upd_node[NWAYS_W-1:0], upd_idx[l]}; // descend
            end
         end
      end
   end

   line_state_regfile #(
      .ADDR_W(`CACHE_DIR_NLINES_W),
      .DATA_W(STATE_W)
   ) u_state (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .we_i    (we_i),
      .addr_i  (line_i),
      .w_data_i(state_d),
      .r_data_o(state_q)
   );

endmodule

//--- logic/cache_dir_resp_pkg.sv
`include "cache_dir_params.svh"

// result side of the directory: way vectors and the lookup response
package cache_dir_resp_pkg;

   typedef logic [`CACHE_DIR_NWAYS-1:0]   way_vec_t; // one bit per way
   typedef logic [`CACHE_DIR_NWAYS_W-1:0] way_idx_t; // encoded way

   typedef struct packed {
      logic                     hit;         // tag found in the line
      way_idx_t                 way;         // hit way, or allocated way on a miss
      logic                     evict_valid; // a valid tag was replaced
      logic [`CACHE_DIR_TAG_W-1:0] evict_tag; // replaced tag, zero when nothing evicted
   } lookup_resp_t;

   // one-hot to index, or-reduction so a zero vector gives way 0
   function automatic way_idx_t onehot_to_idx(way_vec_t vec);
      way_idx_t idx;
      idx = '0;
      for (int i = 0; i < `CACHE_DIR_NWAYS; i++) begin
         if (vec[i]) begin
            idx |= way_idx_t'(i);
         end
      end
      return idx;
   endfunction

endpackage

//--- logic/cache_dir_sweep_cnt.sv
`timescale 1ns/1ps

`include "cache_dir_params.svh"

// flush timer, visits every line once
module cache_dir_sweep_cnt import cache_dir_addr_pkg::*; (
   input  logic      clk_i,
   input  logic      arst_n_i,
   input  logic      en_i,   // high for the whole sweep
   output line_idx_t line_o, // line cleared this cycle
   output logic      last_o  // final line of the walk
);

   line_idx_t line_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         line_q <= '0;
      end else if (en_i) begin
         // natural wrap brings it back to 0 for the next flush
         line_q <= line_q + 1'b1;
      end
   end

   assign line_o = line_q;
   assign last_o = &line_q; // line NLINES-1

endmodule

//--- logic/cache_dir_tag_store.sv
`timescale 1ns/1ps

`include "cache_dir_params.svh"

// valid and tag arrays, parallel compare over the ways of one line
module cache_dir_tag_store import cache_dir_addr_pkg::*, cache_dir_resp_pkg::*; (
   input  logic        clk_i,
   input  logic        arst_n_i,
   input  lookup_req_t req_i,
   input  logic        alloc_i,       // lookup cycle, write the victim on a miss
   input  logic        clear_i,       // sweep cycle
   input  line_idx_t   clear_line_i,
   input  way_vec_t    victim_1hot_i,
   output way_vec_t    hit_1hot_o,
   output way_idx_t    hit_idx_o,
   output logic        evict_valid_o,
   output tag_t        evict_tag_o
);

   localparam int NLINES = 1 << `CACHE_DIR_NLINES_W;
   localparam int NWAYS  = `CACHE_DIR_NWAYS;

   way_vec_t  valid_q [NLINES];
   tag_t      tag_q   [NLINES][NWAYS];
   tag_t      req_tag;
   line_idx_t req_line;
   way_vec_t  line_valid;
   logic      alloc_we;

   assign req_tag    = req_i.addr.fields.tag;
   assign req_line   = req_i.addr.fields.line; // offset is ignored
   assign line_valid = valid_q[req_line];

   always_comb begin
      hit_1hot_o  = '0;
      evict_tag_o = '0;
      for (int w = 0; w < NWAYS; w++) begin
         hit_1hot_o[w] = line_valid[w] && (tag_q[req_line][w] == req_tag);
         if (victim_1hot_i[w]) begin
            evict_tag_o |= tag_q[req_line][w]; // and-or mux on the victim
         end
      end
   end

   assign hit_idx_o = onehot_to_idx(hit_1hot_o);
   assign alloc_we  = alloc_i && !(|hit_1hot_o); // only a miss allocates

   // old content of the victim is reported before it is overwritten
   assign evict_valid_o = alloc_we && |(line_valid & victim_1hot_i);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int l = 0; l < NLINES; l++) begin
            valid_q[l] <= '0;
         end
      end else if (clear_i) begin
         valid_q[clear_line_i] <= '0; // one line per sweep cycle
      end else if (alloc_we) begin
         valid_q[req_line] <= line_valid | victim_1hot_i;
      end
   end

   // tags are meaningless while the valid bit is low
   always_ff @(posedge clk_i) begin
      if (alloc_we) begin
         for (int w = 0; w < NWAYS; w++) begin
            if (victim_1hot_i[w]) begin
               tag_q[req_line][w] <= req_tag;
            end
         end
      end
   end

endmodule

//--- logic/cache_dir_top.sv
`timescale 1ns/1ps

`include "cache_dir_params.svh"

// tag directory of a 4-way, 8-line cache
module cache_dir_top import cache_dir_addr_pkg::*, cache_dir_resp_pkg::*; #(
   parameter int REP_POLICY = `CACHE_DIR_DEFAULT_POLICY
) (
   input  logic         clk_i,
   input  logic         arst_n_i,
   input  logic         req_i,
   input  cache_addr_t  addr_i,
   input  logic         flush_i,
   output logic         busy_o,
   output logic         resp_valid_o,
   output lookup_resp_t resp_o,
   output logic         flush_done_o
);

   lookup_req_t lookup_req;
   logic        lookup, sweep, sweep_last;
   line_idx_t   sweep_line;
   line_idx_t   rep_line;
   way_vec_t    hit_1hot, victim_1hot, upd_1hot;
   way_idx_t    hit_idx;
   logic        evict_valid;
   tag_t        evict_tag;

   // history follows the request line, or the swept line during a flush
   assign rep_line = sweep ? sweep_line : lookup_req.addr.fields.line;
   // hit way on a hit, allocated way on a miss, nothing while sweeping
   assign upd_1hot = sweep ? '0 : ((|hit_1hot) ? hit_1hot : victim_1hot);

   cache_dir_ctrl_fsm u_ctrl (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .req_i(req_i), .addr_i(addr_i), .flush_i(flush_i), .sweep_last_i(sweep_last),
      .hit_1hot_i(hit_1hot), .hit_idx_i(hit_idx), .victim_1hot_i(victim_1hot),
      .evict_valid_i(evict_valid), .evict_tag_i(evict_tag),
      .req_o(lookup_req), .lookup_o(lookup), .sweep_o(sweep), .busy_o(busy_o),
      .resp_valid_o(resp_valid_o), .resp_o(resp_o), .flush_done_o(flush_done_o)
   );

   cache_dir_sweep_cnt u_sweep (
      .clk_i(clk_i), .arst_n_i(arst_n_i), .en_i(sweep),
      .line_o(sweep_line), .last_o(sweep_last)
   );

   cache_dir_tag_store u_tags (
      .clk_i(clk_i), .arst_n_i(arst_n_i), .req_i(lookup_req),
      .alloc_i(lookup), .clear_i(sweep), .clear_line_i(sweep_line),
      .victim_1hot_i(victim_1hot), .hit_1hot_o(hit_1hot), .hit_idx_o(hit_idx),
      .evict_valid_o(evict_valid), .evict_tag_o(evict_tag)
   );

   cache_dir_replace #(.REP_POLICY(REP_POLICY)) u_replace (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .we_i(lookup | sweep), // every lookup updates, every sweep cycle clears
      .line_i(rep_line), .way_hit_1hot_i(upd_1hot), .way_select_o(victim_1hot)
   );

endmodule

//--- logic/line_state_regfile.sv
`timescale 1ns/1ps

// one word per cache line, written on we_i, read without latency
module line_state_regfile #(
   parameter int ADDR_W = 3,
   parameter int DATA_W = 3
) (
   input  logic              clk_i,
   input  logic              arst_n_i,
   input  logic              we_i,
   input  logic [ADDR_W-1:0] addr_i,
   input  logic [DATA_W-1:0] w_data_i,
   output logic [DATA_W-1:0] r_data_o
);

   localparam int DEPTH = 1 << ADDR_W;

   logic [DATA_W-1:0] mem_q [DEPTH]; // replacement state, one entry per line

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem_q[i] <= '0; // every line starts with no history
         end
      end else if (we_i) begin
         mem_q[addr_i] <= w_data_i;
      end
   end

   assign r_data_o = mem_q[addr_i]; // same address for read and write

endmodule

//--- verif/cache_dir_properties.sv
`timescale 1ns/1ps

`include "cache_dir_params.svh"

// protocol checks on the directory outputs
module cache_dir_properties import cache_dir_resp_pkg::*; (
   input logic     clk_i,
   input logic     arst_n_i,
   input logic     resp_valid_i,
   input logic     flush_done_i,
   input way_vec_t way_select_i  // victim vector inside the replacement unit
);

   a_resp_pulse : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      resp_valid_i |=> !resp_valid_i)
      else $error("resp_valid_o stayed high for more than one cycle");

   a_done_pulse : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      flush_done_i |=> !flush_done_i)
      else $error("flush_done_o stayed high for more than one cycle");

   // a lookup and a flush never finish together
   a_no_overlap : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !(resp_valid_i && flush_done_i))
      else $error("resp_valid_o and flush_done_o high in the same cycle");

   a_victim_onehot : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot(way_select_i))
      else $error("victim way vector is not one-hot");

endmodule

bind cache_dir_top cache_dir_properties u_props (
   .clk_i       (clk_i),
   .arst_n_i    (arst_n_i),
   .resp_valid_i(resp_valid_o),
   .flush_done_i(flush_done_o),
   .way_select_i(victim_1hot)
);

//--- verif/cache_dir_tb.sv
`timescale 1ns/1ps

`include "cache_dir_params.svh"

module cache_dir_tb import cache_dir_addr_pkg::*, cache_dir_resp_pkg::*; #(
   parameter int REP_POLICY = `CACHE_DIR_DEFAULT_POLICY
);

   localparam int WAIT_LIMIT = 50; // edges before a wait gives up

   logic         clk_i, arst_n_i, req_i, flush_i;
   cache_addr_t  addr_i;
   logic         busy_o, resp_valid_o, flush_done_o;
   lookup_resp_t resp_o;

   // reference model of the directory
   logic         m_valid [8][4];
   logic [10:0]  m_tag   [8][4];
   logic [3:0]   m_state [8];   // tree uses bits 1..3, mru all four

   lookup_resp_t exp_q[$];      // expected responses in issue order
   lookup_resp_t cmp_exp;
   lookup_resp_t last_exp;      // model answer to the latest lookup
   int           errors = 0;
   int           test_start;
   int           seed = 74;
   way_idx_t     alloc_way [8][4];

   cache_dir_top #(.REP_POLICY(REP_POLICY)) dut (.*);

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   function automatic int victim_of(int line);
      int half;
      if (REP_POLICY == `CACHE_DIR_PLRU_TREE) begin
         // root picks the half, the child picks the way in it
         half = int'(m_state[line][1]);
         return 2 * half + int'(m_state[line][2 + half]);
      end
      for (int w = 0; w < 4; w++) begin
         if (!m_state[line][w]) return w; // lowest clear mru bit
      end
      return 0;
   endfunction

   function automatic void touch(int line, int way);
      if (REP_POLICY == `CACHE_DIR_PLRU_TREE) begin
         m_state[line][1] = ~way[1];                // root points away from used half
         m_state[line][2 + way[1]] = ~way[0];
      end else begin
         m_state[line][way] = 1'b1;
         if (m_state[line] == 4'b1111) m_state[line] = 4'b0001 << way; // saturation
      end
   endfunction

   function automatic lookup_resp_t ref_lookup(logic [15:0] raw);
      lookup_resp_t r;
      int           line;
      int           hw;
      int           vw;
      logic [10:0]  tag;
      tag  = raw[15:5];
      line = int'(raw[4:2]);   // offset bits play no part
      r    = '0;
      hw   = -1;
      for (int w = 0; w < 4; w++) begin
         if (m_valid[line][w] && m_tag[line][w] == tag) hw = w;
      end
      if (hw >= 0) begin
         r.hit = 1'b1;
         r.way = way_idx_t'(hw);
         touch(line, hw);
      end else begin
         vw            = victim_of(line);
         r.way         = way_idx_t'(vw);
         r.evict_valid = m_valid[line][vw];
         r.evict_tag   = m_valid[line][vw] ? m_tag[line][vw] : '0;
         m_valid[line][vw] = 1'b1;
         m_tag[line][vw]   = tag;
         touch(line, vw);
      end
      return r;
   endfunction

   function automatic void clear_model();
      for (int l = 0; l < 8; l++) begin
         m_state[l] = '0;
         for (int w = 0; w < 4; w++) m_valid[l][w] = 1'b0;
      end
   endfunction

   // every response is checked against the oldest expected one
   always @(negedge clk_i) begin
      if (arst_n_i && resp_valid_o) begin
         assert (exp_q.size() != 0) else begin
            errors++;
            $display("response at %0t arrived with no lookup outstanding", $time);
         end
         if (exp_q.size() != 0) begin
            cmp_exp = exp_q.pop_front();
            assert (resp_o == cmp_exp) else begin
               errors++;
               $display("mismatch at %0t: got hit %0b way %0d ev %0b tag %h, exp %0b %0d %0b %h",
                        $time, resp_o.hit, resp_o.way, resp_o.evict_valid, resp_o.evict_tag,
                        cmp_exp.hit, cmp_exp.way, cmp_exp.evict_valid, cmp_exp.evict_tag);
            end
         end
      end
   end

   task automatic abort_on_timeout(string what);
      $display("timeout at %0t: %s never came", $time, what);
      $display("Simulation failed");
      $finish;
   endtask

   // one lookup, returns what the DUT answered
   task automatic issue_lookup(input logic [15:0] raw, output lookup_resp_t got);
      int n;
      n = 0;
      @(posedge clk_i);
      req_i      <= 1'b1;
      addr_i.raw <= raw;
      last_exp = ref_lookup(raw);
      exp_q.push_back(last_exp);
      @(posedge clk_i);               // DUT samples the request here
      req_i <= 1'b0;
      do begin
         @(negedge clk_i);
         n++;
         if (n == 1) assert (busy_o) else begin
            errors++;
            $display("mismatch at %0t: busy_o low during lookup", $time);
         end
      end while (!resp_valid_o && n < WAIT_LIMIT);
      if (!resp_valid_o) begin
         abort_on_timeout("lookup response");
      end else begin
         got = resp_o;
         assert (n == 2 && !busy_o) else begin
            errors++;
            $display("mismatch at %0t: response after %0d edges, busy %0b", $time, n, busy_o);
         end
      end
   endtask

   task automatic run_flush();
      int n;
      n = 0;
      @(posedge clk_i);
      flush_i <= 1'b1;
      @(posedge clk_i);
      flush_i <= 1'b0;
      clear_model();
      do begin
         @(negedge clk_i);
         n++;
      end while (!flush_done_o && n < WAIT_LIMIT);
      if (!flush_done_o) begin
         abort_on_timeout("flush_done_o");
      end else begin
         assert (n == 9 && !busy_o) else begin
            errors++;
            $display("mismatch at %0t: flush done after %0d edges", $time, n);
         end
      end
   endtask

   function automatic logic [15:0] fixed_addr(int line, int k);
      return {11'h100 + 11'(k), 3'(line), 2'b00};
   endfunction

   task automatic report_test(int num, string name);
      $display("test %0d %s: %0d errors", num, name, errors - test_start);
      test_start = errors;
   endtask

   initial begin
      lookup_resp_t got;
      logic [15:0]  raw;
      req_i    = 1'b0;
      flush_i  = 1'b0;
      addr_i   = '0;
      arst_n_i = 1'b0;
      clear_model();
      repeat (2) @(posedge clk_i);
      arst_n_i <= 1'b1;
      test_start = 0;

      for (int l = 0; l < 8; l++) begin   // fill every line from empty
         for (int k = 0; k < 4; k++) begin
            issue_lookup(fixed_addr(l, k), got);
            alloc_way[l][k] = last_exp.way; // way the policy gives this tag
            assert (!got.hit && !got.evict_valid && (k != 0 || got.way == 0)) else begin
               errors++;
               $display("mismatch at %0t: bad allocation on empty line %0d", $time, l);
            end
         end
      end
      report_test(1, "cold misses");

      for (int l = 0; l < 8; l++) begin
         for (int k = 0; k < 4; k++) begin
            issue_lookup(fixed_addr(l, k), got);
            assert (got.hit && got.way == alloc_way[l][k]) else begin
               errors++;
               $display("mismatch at %0t: line %0d tag %0d not hit in its way", $time, l, k);
            end
         end
      end
      report_test(2, "repeat hits");

      for (int i = 0; i < 300; i++) begin
         // six tags over four ways keeps evictions busy
         raw = {11'h100 + 11'($unsigned($random(seed)) % 6), 3'($random(seed)),
                2'($random(seed))};
         issue_lookup(raw, got);
      end
      report_test(3, "random mix");

      for (int i = 0; i < 16; i++) begin
         issue_lookup(fixed_addr(i % 8, i % 5), got); // latency checked per lookup
      end
      report_test(4, "latency");

      run_flush();
      for (int l = 0; l < 8; l++) begin
         issue_lookup(fixed_addr(l, 0), got);
         assert (!got.hit && !got.evict_valid && got.way == 0) else begin
            errors++;
            $display("mismatch at %0t: line %0d not empty after flush", $time, l);
         end
      end
      report_test(5, "flush");

      repeat (3) @(negedge clk_i);
      assert (exp_q.size() == 0) else begin
         errors++;
         $display("%0d expected responses never arrived", exp_q.size());
      end
      $display("5 tests run, %0d errors", errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
